// File: Bender.yml
package:
  name: spi_register_set

sources:
  # packages first, the design files use their scoped names
  - design/reg_map_pkg.sv
  - design/wb_pkg.sv
  - design/spi_frame_slave.sv
  - design/config_register.sv
  - design/readback_mux.sv
  - design/spi_register_set.sv
  - target: test
    files:
      - testbench/spi_register_set_properties.sv
      - testbench/tb_spi_register_set.sv

// File: all.f
design/reg_map_pkg.sv
design/wb_pkg.sv
design/spi_frame_slave.sv
design/config_register.sv
design/readback_mux.sv
design/spi_register_set.sv
testbench/spi_register_set_properties.sv
testbench/tb_spi_register_set.sv

// File: design/config_register.sv
`timescale 1ns/1ps
`default_nettype none

module config_register #(
  parameter reg_map_pkg::reg_addr_t ADDR = '0  // address this slot answers to
) (
  input  logic                   clk,
  input  logic                   rst,
  input  wb_pkg::wb_req_t        wb_req,
  output reg_map_pkg::reg_data_t value,
  output logic                   hit
);

  logic busy;  // local copy of the ack phase
  logic wr_en;

  assign hit = (wb_req.adr == ADDR);

  // first cycle of a write strobe only, the ack cycle is not a second write
  assign wr_en = wb_req.cyc && wb_req.stb && wb_req.we && hit && !busy;

  // tracks the fixed one cycle ack of the readback mux
  always_ff @(posedge clk)
  begin
    if (rst)
      busy <= 1'b0;
    else
      busy <= wb_req.cyc && wb_req.stb && !busy;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      value <= '0;
    else if (wr_en)
      value <= wb_req.dat;
  end

endmodule

`default_nettype wire

// File: design/readback_mux.sv
`timescale 1ns/1ps
`default_nettype none

module readback_mux (
  input  logic                   clk,
  input  logic                   rst,
  input  wb_pkg::wb_req_t        wb_req,
  input  reg_map_pkg::reg_data_t slot_value [reg_map_pkg::NUM_SLOTS],
  input  logic [reg_map_pkg::NUM_SLOTS-1:0] slot_hit,
  input  reg_map_pkg::reg_data_t reg_status,
  output wb_pkg::wb_rsp_t        wb_rsp
);

  logic                   ack_q;
  reg_map_pkg::reg_data_t dat_q;
  reg_map_pkg::reg_data_t rd_sel;

  // priority: slot hit, then status, then the fixed pattern
  always_comb
  begin
    rd_sel = reg_map_pkg::UNMAPPED_DATA;
    if (wb_req.adr == reg_map_pkg::ADDR_STATUS)
      rd_sel = reg_status;
    for (int i = 0; i < reg_map_pkg::NUM_SLOTS; i++)
    begin
      if (slot_hit[i])
        rd_sel = slot_value[i];  // slot addresses are unique
    end
  end

  // ack one cycle after a new strobe, every address answers
  always_ff @(posedge clk)
  begin
    if (rst)
      ack_q <= 1'b0;
    else
      ack_q <= wb_req.cyc && wb_req.stb && !ack_q;
  end

  always_ff @(posedge clk)
  begin
    dat_q <= rd_sel;  // valid in the ack cycle, adr is held until then
  end

  assign wb_rsp = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

// File: design/reg_map_pkg.sv
`default_nettype none

package reg_map_pkg;

  typedef logic [6:0]  reg_addr_t;  // 7 bit register address from the header byte
  typedef logic [31:0] reg_data_t;  // one register word

  // writable registers, all built from the same slot module
  localparam int NUM_SLOTS = 5;

  // slot number to address, in port order of the top level
  localparam reg_addr_t SLOT_ADDR [NUM_SLOTS] = '{
    7'd8,   // spi_mux
    7'd9,   // reg_4094
    7'd12,  // mode
    7'd14,  // direct
    7'd18   // seq_mode
  };

  localparam reg_addr_t ADDR_STATUS = 7'd17;  // read only, driven from outside

  // returned for any address nobody answers
  localparam reg_data_t UNMAPPED_DATA = 32'h000f0f0f;

endpackage

`default_nettype wire

// File: design/spi_frame_slave.sv
`timescale 1ns/1ps
`default_nettype none

module spi_frame_slave #(
  parameter int SCK_SYNC_STAGES = 2  // synchronizer depth, 2 or more
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            sck,
  input  logic            cs_n,
  input  logic            din,
  input  wb_pkg::wb_rsp_t wb_rsp,
  output logic            dout,
  output wb_pkg::wb_req_t wb_req
);

  localparam logic [5:0] FRAME_BITS = 6'd40;  // header byte plus 32 data bits

  typedef enum logic [1:0] {idle, shift, read_cycle, write_cycle} state_t;

  state_t                     state;
  logic [SCK_SYNC_STAGES-1:0] sck_sync;
  logic [SCK_SYNC_STAGES-1:0] cs_n_sync;
  logic [SCK_SYNC_STAGES-1:0] din_sync;
  logic                       sck_s;
  logic                       cs_n_s;
  logic                       din_s;
  logic                       sck_q;     // previous synchronized sck
  logic                       sck_rise;  // registered edge pulses
  logic                       sck_fall;
  logic                       din_bit;   // din aligned with sck_rise
  logic                       sample;
  logic [5:0]                 bit_cnt;
  logic                       wr_n;      // header bit 7, 0 means write
  reg_map_pkg::reg_data_t     in_sr;
  reg_map_pkg::reg_data_t     out_sr;
  logic                       dout_q;

  assign sck_s  = sck_sync[SCK_SYNC_STAGES-1];
  assign cs_n_s = cs_n_sync[SCK_SYNC_STAGES-1];
  assign din_s  = din_sync[SCK_SYNC_STAGES-1];

  // synchronizers and edge detect, all three lines share the same depth
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sck_sync  <= '0;
      cs_n_sync <= '1;  // deselected
      din_sync  <= '0;
      sck_q     <= 1'b0;
      sck_rise  <= 1'b0;
      sck_fall  <= 1'b0;
      din_bit   <= 1'b0;
    end
    else
    begin
      sck_sync  <= {sck_sync[SCK_SYNC_STAGES-2:0], sck};
      cs_n_sync <= {cs_n_sync[SCK_SYNC_STAGES-2:0], cs_n};
      din_sync  <= {din_sync[SCK_SYNC_STAGES-2:0], din};
      sck_q     <= sck_s;
      sck_rise  <= sck_s & ~sck_q;
      sck_fall  <= ~sck_s & sck_q;
      din_bit   <= din_s;
    end
  end

  // take a bit on each rising edge, nothing after the 40th
  assign sample = (state == shift) && !cs_n_s && sck_rise && (bit_cnt != FRAME_BITS);

  // input shifter, the header byte falls off the top
  always_ff @(posedge clk)
  begin
    if (sample)
      in_sr <= {in_sr[30:0], din_bit};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= idle;
      bit_cnt <= '0;
      wr_n    <= 1'b1;
      out_sr  <= '0;
      dout_q  <= 1'b0;
      wb_req  <= '0;
    end
    else
    begin
      case (state)
        idle:
        begin
          bit_cnt <= '0;
          out_sr  <= '0;  // dout stays low through the header
          dout_q  <= 1'b0;
          if (!cs_n_s)
            state <= shift;
        end
        shift:
        begin
          if (cs_n_s)
            state <= idle;  // frame over, a short one is dropped here
          else
          begin
            if (sample)
            begin
              bit_cnt <= bit_cnt + 6'd1;
              if (bit_cnt == 6'd7)
              begin
                // header complete, fetch the addressed register
                wr_n          <= in_sr[6];
                wb_req.cyc    <= 1'b1;
                wb_req.stb    <= 1'b1;
                wb_req.we     <= 1'b0;
                wb_req.adr    <= {in_sr[5:0], din_bit};
                state         <= read_cycle;
              end
              else if (bit_cnt == FRAME_BITS - 6'd1 && !wr_n)
              begin
                wb_req.cyc <= 1'b1;
                wb_req.stb <= 1'b1;
                wb_req.we  <= 1'b1;
                wb_req.dat <= {in_sr[30:0], din_bit};  // adr still held from header
                state      <= write_cycle;
              end
            end
            if (sck_fall)
            begin
              dout_q <= out_sr[31];  // msb first, zero fill after bit 0
              out_sr <= {out_sr[30:0], 1'b0};
            end
          end
        end
        read_cycle:
        begin
          if (wb_rsp.ack)
          begin
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            out_sr     <= wb_rsp.dat;  // first bit goes out on next falling sck
            state      <= shift;
          end
        end
        write_cycle:
        begin
          if (wb_rsp.ack)
          begin
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            wb_req.we  <= 1'b0;
            state      <= shift;  // wait for cs_n, later bits ignored
          end
        end
        default: state <= idle;
      endcase
      // last stage before cs_n_s, so dout drops on the edge where cs_n_s rises
      if (cs_n_sync[SCK_SYNC_STAGES-2])
        dout_q <= 1'b0;
    end
  end

  assign dout = dout_q;  // low as soon as the frame ends

endmodule

`default_nettype wire

// File: design/spi_register_set.sv
`timescale 1ns/1ps
`default_nettype none

module spi_register_set #(
  parameter int SCK_SYNC_STAGES = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   sck,
  input  logic                   cs_n,
  input  logic                   din,
  input  reg_map_pkg::reg_data_t reg_status,  // external status word
  output logic                   dout,
  output reg_map_pkg::reg_data_t reg_spi_mux,
  output reg_map_pkg::reg_data_t reg_4094,
  output reg_map_pkg::reg_data_t reg_mode,
  output reg_map_pkg::reg_data_t reg_direct,
  output reg_map_pkg::reg_data_t reg_seq_mode
);

  wb_pkg::wb_req_t                       wb_req;
  wb_pkg::wb_rsp_t                       wb_rsp;
  reg_map_pkg::reg_data_t                slot_value [reg_map_pkg::NUM_SLOTS];
  logic [reg_map_pkg::NUM_SLOTS-1:0]     slot_hit;

  spi_frame_slave #(
    .SCK_SYNC_STAGES(SCK_SYNC_STAGES)
  ) frame_slave_i (
    .clk   (clk),
    .rst   (rst),
    .sck   (sck),
    .cs_n  (cs_n),
    .din   (din),
    .wb_rsp(wb_rsp),
    .dout  (dout),
    .wb_req(wb_req)
  );

  // one slot per writable register, order as in SLOT_ADDR
  for (genvar i = 0; i < reg_map_pkg::NUM_SLOTS; i++)
  begin : gen_slot
    config_register #(
      .ADDR(reg_map_pkg::SLOT_ADDR[i])
    ) slot_i (
      .clk   (clk),
      .rst   (rst),
      .wb_req(wb_req),
      .value (slot_value[i]),
      .hit   (slot_hit[i])
    );
  end

  readback_mux readback_mux_i (
    .clk       (clk),
    .rst       (rst),
    .wb_req    (wb_req),
    .slot_value(slot_value),
    .slot_hit  (slot_hit),
    .reg_status(reg_status),
    .wb_rsp    (wb_rsp)
  );

  assign reg_spi_mux  = slot_value[0];  // address 8
  assign reg_4094     = slot_value[1];  // address 9
  assign reg_mode     = slot_value[2];  // address 12
  assign reg_direct   = slot_value[3];  // address 14
  assign reg_seq_mode = slot_value[4];  // address 18

endmodule

`default_nettype wire

// File: design/wb_pkg.sv
`default_nettype none

package wb_pkg;

  // master to slave, wishbone classic without stall
  typedef struct packed {
    logic                   cyc;  // bus cycle in progress
    logic                   stb;  // transfer strobe
    logic                   we;   // 1 write, 0 read
    reg_map_pkg::reg_addr_t adr;
    reg_map_pkg::reg_data_t dat;  // write data
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic                   ack;  // one cycle pulse per transfer
    reg_map_pkg::reg_data_t dat;  // read data, valid with ack
  } wb_rsp_t;

endpackage

`default_nettype wire

// File: testbench/spi_register_set_properties.sv
`timescale 1ns/1ps
`default_nettype none

module spi_register_set_properties (
  input wire logic            clk,
  input wire logic            rst,
  input wire wb_pkg::wb_req_t wb_req,
  input wire wb_pkg::wb_rsp_t wb_rsp,
  input wire logic            dout,
  input wire logic            cs_n_s  // cs_n after the synchronizer
);

  int assert_fails = 0;  // read by the testbench at the end of the run

  // the slave answers one cycle after the strobe, never in the same cycle
  ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
    (wb_req.cyc && wb_req.stb && !wb_rsp.ack) |=> wb_rsp.ack)
  else
  begin
    assert_fails++;
    $error("ack did not follow a new strobe after one cycle");
  end

  ack_not_early: assert property (@(posedge clk) disable iff (rst)
    $rose(wb_req.stb) |-> !wb_rsp.ack)
  else
  begin
    assert_fails++;
    $error("ack came together with a new strobe");
  end

  stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
    wb_req.stb |-> wb_req.cyc)
  else
  begin
    assert_fails++;
    $error("stb high outside a bus cycle");
  end

  cyc_drops: assert property (@(posedge clk) disable iff (rst)
    wb_rsp.ack |=> !wb_req.cyc)
  else
  begin
    assert_fails++;
    $error("cyc still high in the cycle after ack");
  end

  dout_idle_low: assert property (@(posedge clk) disable iff (rst)
    cs_n_s |-> !dout)  // no drive outside a frame
  else
  begin
    assert_fails++;
    $error("dout high while deselected");
  end

endmodule

bind spi_register_set spi_register_set_properties props_i (
  .clk   (clk),
  .rst   (rst),
  .wb_req(wb_req),
  .wb_rsp(wb_rsp),
  .dout  (dout),
  .cs_n_s(frame_slave_i.cs_n_s)
);

`default_nettype wire

// File: testbench/spi_register_set_tests.txt
# op addr data expected, all hex
# op: W write, R read, S write cut short, T status read (expected from reg_status)
W 08 a5a55a5a a5a55a5a
W 09 12345678 12345678
W 0c deadbeef deadbeef
W 0e 0000ffff 0000ffff
W 12 80000001 80000001
R 08 00000000 a5a55a5a
R 0c 00000000 deadbeef
R 12 00000000 80000001
T 11 00000000 00000000
R 05 00000000 000f0f0f
W 11 ffffffff 00000000
W 30 cafef00d 00000000
S 09 55555555 12345678
R 09 00000000 12345678
R 0e 00000000 0000ffff

// File: testbench/tb_spi_register_set.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_register_set;

  logic        clk;
  logic        rst;
  logic        sck;
  logic        cs_n;
  logic        din;
  logic        dout;
  logic [31:0] reg_status;
  logic [31:0] ports [5];   // register outputs in address order
  logic [31:0] shadow [5];  // expected port values
  int          port_addr [5];
  int          errors;
  int          cycles;
  int          limit;       // 0 until the test count is known
  logic [7:0]  op_q [$];
  logic [6:0]  adr_q [$];
  logic [31:0] dat_q [$];
  logic [31:0] exp_q [$];

  spi_register_set spi_register_set_i (
    .clk         (clk),
    .rst         (rst),
    .sck         (sck),
    .cs_n        (cs_n),
    .din         (din),
    .reg_status  (reg_status),
    .dout        (dout),
    .reg_spi_mux (ports[0]),
    .reg_4094    (ports[1]),
    .reg_mode    (ports[2]),
    .reg_direct  (ports[3]),
    .reg_seq_mode(ports[4])
  );

  always #10 clk = ~clk;  // 20 ns period

  // run limit, 2 x tests x 700 clk
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit)
    begin
      errors = errors + 1;
      $display("run timed out after %0d clk cycles, errors: %0d", cycles, errors);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic int port_index(input logic [6:0] adr);
    int idx;
    idx = -1;  // status and unmapped have no port
    for (int k = 0; k < 5; k++)
    begin
      if (port_addr[k] == adr)
        idx = k;
    end
    return idx;
  endfunction

  task automatic check_ports();
    for (int k = 0; k < 5; k++)
    begin
      if (ports[k] !== shadow[k])
      begin
        $display("[FAIL] %0t ns: port addr %0d expected %08h got %08h",
                 $time, port_addr[k], shadow[k], ports[k]);
        errors++;
      end
    end
  endtask

  // mode 0 host, sck low 8 clk then high 8 clk per bit, msb first
  task automatic send_frame(input logic [7:0] header, input logic [31:0] data,
                            input int nbits, output logic [31:0] rd);
    logic [39:0] frame;
    frame = {header, data};
    rd    = '0;
    cs_n  = 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      din = frame[39-i];  // changes with the falling sck
      repeat (8) @(negedge clk);
      sck = 1'b1;
      if (i >= 8)
        rd = {rd[30:0], dout};  // bits 9 to 40 carry read data
      repeat (8) @(negedge clk);
      sck = 1'b0;
    end
    repeat (8) @(negedge clk);
    cs_n = 1'b1;
    din  = 1'b0;
    repeat (16) @(negedge clk);  // gap, covers sync depth plus 3 for a write
  endtask

  initial
  begin
    int          fd;
    int          c;
    int          r;
    int          k;
    logic [1023:0] skip_line;
    logic [6:0]  a;
    logic [31:0] d;
    logic [31:0] e;
    logic [31:0] rd;
    clk        = 1'b0;
    rst        = 1'b1;
    sck        = 1'b0;
    cs_n       = 1'b1;
    din        = 1'b0;
    reg_status = '0;
    errors     = 0;
    cycles     = 0;
    limit      = 0;
    void'($urandom(32'h7d03));  // seeds the generator once
    port_addr  = '{8, 9, 12, 14, 18};
    shadow     = '{default: '0};
    fd = $fopen("testbench/spi_register_set_tests.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the test file");
      errors++;
    end
    else
    begin
      c = $fgetc(fd);
      while (c != -1)
      begin
        if (c == "#")
          r = $fgets(skip_line, fd);  // column notes
        else if (c == "W" || c == "R" || c == "S" || c == "T")
        begin
          r = $fscanf(fd, "%h %h %h", a, d, e);
          if (r != 3)
          begin
            $display("could not read a test line, only %0d fields", r);
            errors++;
          end
          op_q.push_back(c[7:0]);
          adr_q.push_back(a);
          dat_q.push_back(d);
          exp_q.push_back(e);
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
    end
    limit = 2 * op_q.size() * 700;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_ports();  // all zero out of reset
    for (int t = 0; t < op_q.size(); t++)
    begin
      a = adr_q[t];
      e = exp_q[t];
      if (op_q[t] == "T")
      begin
        e          = $urandom;
        reg_status = e;  // the file value is not used here
      end
      if (op_q[t] == "R" || op_q[t] == "T")
      begin
        send_frame({1'b1, a}, 32'h0, 40, rd);
        if (rd !== e)
        begin
          $display("[FAIL] %0t ns: read addr %0d expected %08h got %08h", $time, a, e, rd);
          errors++;
        end
      end
      else
      begin
        send_frame({1'b0, a}, dat_q[t], (op_q[t] == "S") ? 20 : 40, rd);
        k = port_index(a);
        if (k >= 0)
          shadow[k] = e;  // other ports keep their value
        check_ports();
      end
    end
    errors = errors + spi_register_set_i.props_i.assert_fails;
    $display("run complete, errors: %0d", errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
